/* verilog/id_config.svh */
/* Decode stage widths and instruction field positions.
   Field positions follow the classic 32-bit MIPS encoding */
`ifndef ID_CONFIG_SVH
`define ID_CONFIG_SVH

`define ID_DATA_WIDTH     32   // Data and address width
`define ID_REG_COUNT      32
`define ID_REG_ADDR_WIDTH 5
`define ID_LINK_REG       31   // jal and linking branches write here
`define ID_INSTR_STEP     4    // Bytes between instructions

////////////////////
// Instruction fields
`define ID_OP_HI    31
`define ID_OP_LO    26
`define ID_RS_HI    25
`define ID_RS_LO    21
`define ID_RT_HI    20
`define ID_RT_LO    16
`define ID_RD_HI    15
`define ID_RD_LO    11
`define ID_SHAMT_HI 10
`define ID_SHAMT_LO 6
`define ID_FUNCT_HI 5
`define ID_FUNCT_LO 0
`define ID_IMM_HI   15
`define ID_IMM_LO   0
`define ID_JIDX_HI  25
`define ID_JIDX_LO  0

`endif

/* verilog/idPkg.sv */
/* Encodings shared by the decode stage and the execute stage behind it.
   Only the kept integer subset has opcode and function codes here */
`include "id_config.svh"

package idPkg;

	// Primary opcodes
	typedef enum logic [`ID_OP_HI-`ID_OP_LO:0] {
		OP_SPECIAL = 6'h00,
		OP_REGIMM  = 6'h01,
		OP_J       = 6'h02,
		OP_JAL     = 6'h03,
		OP_BEQ     = 6'h04,
		OP_BNE     = 6'h05,
		OP_BLEZ    = 6'h06,
		OP_BGTZ    = 6'h07,
		OP_ADDI    = 6'h08,
		OP_ADDIU   = 6'h09,
		OP_SLTI    = 6'h0a,
		OP_SLTIU   = 6'h0b,
		OP_ANDI    = 6'h0c,
		OP_ORI     = 6'h0d,
		OP_XORI    = 6'h0e,
		OP_LUI     = 6'h0f,
		OP_LW      = 6'h23,
		OP_SW      = 6'h2b
	} opcodeT;

	// SPECIAL function field
	typedef enum logic [`ID_FUNCT_HI-`ID_FUNCT_LO:0] {
		FN_SLL  = 6'h00, FN_SRL  = 6'h02, FN_SRA  = 6'h03,
		FN_SLLV = 6'h04, FN_SRLV = 6'h06, FN_SRAV = 6'h07,
		FN_JR   = 6'h08, FN_JALR = 6'h09,
		FN_ADD  = 6'h20, FN_ADDU = 6'h21, FN_SUB  = 6'h22, FN_SUBU = 6'h23,
		FN_AND  = 6'h24, FN_OR   = 6'h25, FN_XOR  = 6'h26, FN_NOR  = 6'h27,
		FN_SLT  = 6'h2a, FN_SLTU = 6'h2b
	} functT;

	// Execute operations, ADD sits at zero
	typedef enum logic [4:0] {
		ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU,
		ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
		ALU_SLT, ALU_SLTU,
		ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLLV, ALU_SRLV, ALU_SRAV,
		ALU_LUI, ALU_NOP
	} aluOpT;

	typedef enum logic [2:0] {
		BR_NONE, BR_EQ, BR_NE, BR_LEZ, BR_GTZ, BR_LTZ, BR_GEZ
	} branchCondT;

endpackage

/* verilog/instrDecoder.sv */
/* Pure combinational decode of one instruction word.
   Anything outside the kept subset comes out as a bubble */
`timescale 1ns/1ps
`include "id_config.svh"

module instrDecoder (
	input  logic [`ID_DATA_WIDTH-1:0]     instr,
	output logic [`ID_REG_ADDR_WIDTH-1:0] rs,
	output logic [`ID_REG_ADDR_WIDTH-1:0] rt,
	output logic [`ID_REG_ADDR_WIDTH-1:0] destSel,
	output logic [`ID_DATA_WIDTH-1:0]     imm,
	output idPkg::aluOpT                  aluOp,
	output idPkg::branchCondT             branchCond,
	output logic                          jump,
	output logic                          jumpReg,
	output logic                          link,
	output logic                          aluSrcImm,
	output logic                          memRead,
	output logic                          memWrite,
	output logic                          memToReg,
	output logic                          regWrite
);

	localparam int IMM_W = `ID_IMM_HI - `ID_IMM_LO + 1;
	localparam logic [`ID_REG_ADDR_WIDTH-1:0] LINK_REG = `ID_LINK_REG;

	idPkg::opcodeT opcode;
	idPkg::functT  funct;
	logic          rdSel;   // R-type writes rd
	logic          zeroExt; // Logical immediates

	assign opcode = idPkg::opcodeT'(instr[`ID_OP_HI:`ID_OP_LO]);
	assign funct  = idPkg::functT'(instr[`ID_FUNCT_HI:`ID_FUNCT_LO]);
	assign rs     = instr[`ID_RS_HI:`ID_RS_LO];
	assign rt     = instr[`ID_RT_HI:`ID_RT_LO];

	assign destSel = rdSel ? instr[`ID_RD_HI:`ID_RD_LO] : (link ? LINK_REG : rt);
	assign imm = zeroExt ? {{(`ID_DATA_WIDTH-IMM_W){1'b0}}, instr[`ID_IMM_HI:`ID_IMM_LO]}
		: {{(`ID_DATA_WIDTH-IMM_W){instr[`ID_IMM_HI]}}, instr[`ID_IMM_HI:`ID_IMM_LO]};

	always_comb begin
		// Bubble unless a case below says otherwise
		aluOp      = idPkg::ALU_NOP;
		branchCond = idPkg::BR_NONE;
		jump       = 1'b0;
		jumpReg    = 1'b0;
		link       = 1'b0;
		aluSrcImm  = 1'b0;
		memRead    = 1'b0;
		memWrite   = 1'b0;
		memToReg   = 1'b0;
		regWrite   = 1'b0;
		rdSel      = 1'b0;
		zeroExt    = 1'b0;
		case (opcode)
			idPkg::OP_SPECIAL: begin
				rdSel = 1'b1;
				case (funct)
					idPkg::FN_SLL:  aluOp = idPkg::ALU_SLL;
					idPkg::FN_SRL:  aluOp = idPkg::ALU_SRL;
					idPkg::FN_SRA:  aluOp = idPkg::ALU_SRA;
					idPkg::FN_SLLV: aluOp = idPkg::ALU_SLLV;
					idPkg::FN_SRLV: aluOp = idPkg::ALU_SRLV;
					idPkg::FN_SRAV: aluOp = idPkg::ALU_SRAV;
					idPkg::FN_ADD:  aluOp = idPkg::ALU_ADD;
					idPkg::FN_ADDU: aluOp = idPkg::ALU_ADDU;
					idPkg::FN_SUB:  aluOp = idPkg::ALU_SUB;
					idPkg::FN_SUBU: aluOp = idPkg::ALU_SUBU;
					idPkg::FN_AND:  aluOp = idPkg::ALU_AND;
					idPkg::FN_OR:   aluOp = idPkg::ALU_OR;
					idPkg::FN_XOR:  aluOp = idPkg::ALU_XOR;
					idPkg::FN_NOR:  aluOp = idPkg::ALU_NOR;
					idPkg::FN_SLT:  aluOp = idPkg::ALU_SLT;
					idPkg::FN_SLTU: aluOp = idPkg::ALU_SLTU;
					idPkg::FN_JR: begin
						jump    = 1'b1;
						jumpReg = 1'b1;
					end
					idPkg::FN_JALR: begin
						jump    = 1'b1;
						jumpReg = 1'b1;
						link    = 1'b1;
						aluOp   = idPkg::ALU_ADD; // Link address built in EX
					end
					default: ;
				endcase
				regWrite = (aluOp != idPkg::ALU_NOP);
			end
			idPkg::OP_REGIMM: begin
				case (rt)
					5'b00000, 5'b10000: branchCond = idPkg::BR_LTZ; // bltz, bltzal
					5'b00001, 5'b10001: branchCond = idPkg::BR_GEZ; // bgez, bgezal
					default: ;
				endcase
				if (branchCond != idPkg::BR_NONE && rt[4]) begin
					link     = 1'b1;
					regWrite = 1'b1;
					aluOp    = idPkg::ALU_ADD;
				end
			end
			idPkg::OP_J: jump = 1'b1;
			idPkg::OP_JAL: begin
				jump     = 1'b1;
				link     = 1'b1;
				regWrite = 1'b1;
				aluOp    = idPkg::ALU_ADD;
			end
			idPkg::OP_BEQ:  branchCond = idPkg::BR_EQ;
			idPkg::OP_BNE:  branchCond = idPkg::BR_NE;
			idPkg::OP_BLEZ: branchCond = idPkg::BR_LEZ;
			idPkg::OP_BGTZ: branchCond = idPkg::BR_GTZ;
			idPkg::OP_ADDI, idPkg::OP_ADDIU, idPkg::OP_SLTI, idPkg::OP_SLTIU,
			idPkg::OP_ANDI, idPkg::OP_ORI, idPkg::OP_XORI, idPkg::OP_LUI: begin
				aluSrcImm = 1'b1;
				regWrite  = 1'b1;
				case (opcode)
					idPkg::OP_ADDI:  aluOp = idPkg::ALU_ADD;
					idPkg::OP_ADDIU: aluOp = idPkg::ALU_ADDU;
					idPkg::OP_SLTI:  aluOp = idPkg::ALU_SLT;
					idPkg::OP_SLTIU: aluOp = idPkg::ALU_SLTU;
					idPkg::OP_ANDI:  aluOp = idPkg::ALU_AND;
					idPkg::OP_ORI:   aluOp = idPkg::ALU_OR;
					idPkg::OP_XORI:  aluOp = idPkg::ALU_XOR;
					default:         aluOp = idPkg::ALU_LUI;
				endcase
				zeroExt = (opcode == idPkg::OP_ANDI) || (opcode == idPkg::OP_ORI)
					|| (opcode == idPkg::OP_XORI);
			end
			idPkg::OP_LW: begin
				aluOp     = idPkg::ALU_ADD; // Base plus offset
				aluSrcImm = 1'b1;
				memRead   = 1'b1;
				memToReg  = 1'b1;
				regWrite  = 1'b1;
			end
			idPkg::OP_SW: begin
				aluOp     = idPkg::ALU_ADD;
				aluSrcImm = 1'b1;
				memWrite  = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

/* verilog/regFile.sv */
/* 32 x 32 register file, two asynchronous reads and one write port.
   No write-to-read bypass, a write shows up after its clock edge */
`timescale 1ns/1ps
`include "id_config.svh"

module regFile (
	input  logic                          CLK,
	input  logic                          RESET,
	input  logic                          wbEnable,
	input  logic [`ID_REG_ADDR_WIDTH-1:0] wbReg,
	input  logic [`ID_DATA_WIDTH-1:0]     wbData,
	input  logic [`ID_REG_ADDR_WIDTH-1:0] rs,
	input  logic [`ID_REG_ADDR_WIDTH-1:0] rt,
	output logic [`ID_DATA_WIDTH-1:0]     readA,
	output logic [`ID_DATA_WIDTH-1:0]     readB
);

	logic [`ID_DATA_WIDTH-1:0] regs [`ID_REG_COUNT];

	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET) begin
			for (int i = 0; i < `ID_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wbEnable && wbReg != '0) begin // Register 0 never written
			regs[wbReg] <= wbData;
		end
	end

	// Register 0 reads as zero
	assign readA = (rs == '0) ? '0 : regs[rs];
	assign readB = (rt == '0) ? '0 : regs[rt];

endmodule

/* verilog/operandForward.sv */
/* Picks the newest in-flight value for each source register.
   Priority EX, MEM, WB, then the register file; register 0 is never forwarded */
`timescale 1ns/1ps
`include "id_config.svh"

module operandForward (
	input  logic [`ID_REG_ADDR_WIDTH-1:0] rs,
	input  logic [`ID_REG_ADDR_WIDTH-1:0] rt,
	input  logic [`ID_DATA_WIDTH-1:0]     readA,
	input  logic [`ID_DATA_WIDTH-1:0]     readB,
	input  logic                          exWriteBack, // Instruction now in EX
	input  logic [`ID_REG_ADDR_WIDTH-1:0] exReg,
	input  logic [`ID_DATA_WIDTH-1:0]     exResult,
	input  logic                          memWbEnable,
	input  logic [`ID_REG_ADDR_WIDTH-1:0] memWbReg,
	input  logic [`ID_DATA_WIDTH-1:0]     memData,
	input  logic                          wbEnable,
	input  logic [`ID_REG_ADDR_WIDTH-1:0] wbReg,
	input  logic [`ID_DATA_WIDTH-1:0]     wbData,
	output logic [`ID_DATA_WIDTH-1:0]     fwdA,
	output logic [`ID_DATA_WIDTH-1:0]     fwdB
);

	function automatic logic [`ID_DATA_WIDTH-1:0] pickNewest(
		input logic [`ID_REG_ADDR_WIDTH-1:0] src,
		input logic [`ID_DATA_WIDTH-1:0]     fileVal
	);
		if (src == '0)
			pickNewest = fileVal; // Already zero from the file
		else if (exWriteBack && exReg == src)
			pickNewest = exResult;
		else if (memWbEnable && memWbReg == src)
			pickNewest = memData;
		else if (wbEnable && wbReg == src)
			pickNewest = wbData;
		else
			pickNewest = fileVal;
	endfunction

	always_comb begin
		fwdA = pickNewest(rs, readA);
		fwdB = pickNewest(rt, readB);
	end

endmodule

/* verilog/branchUnit.sv */
/* Resolves branches and jumps in decode on forwarded operands.
   Targets are relative to the fall-through address of the branch itself */
`timescale 1ns/1ps
`include "id_config.svh"

module branchUnit (
	input  logic [`ID_DATA_WIDTH-1:0] instrAddr,
	input  logic [`ID_DATA_WIDTH-1:0] instr,
	input  logic [`ID_DATA_WIDTH-1:0] imm,
	input  logic [`ID_DATA_WIDTH-1:0] fwdA,
	input  logic [`ID_DATA_WIDTH-1:0] fwdB,
	input  idPkg::branchCondT         branchCond,
	input  logic                      jump,
	input  logic                      jumpReg,
	output logic                      taken,
	output logic [`ID_DATA_WIDTH-1:0] nextAddr,
	output logic                      redirect
);

	localparam logic [`ID_DATA_WIDTH-1:0] STEP = `ID_INSTR_STEP;

	logic [`ID_DATA_WIDTH-1:0] fallThrough;
	logic [`ID_DATA_WIDTH-1:0] branchTarget;
	logic [`ID_DATA_WIDTH-1:0] jumpTarget;
	logic                      negA;
	logic                      zeroA;

	assign fallThrough  = instrAddr + STEP;
	assign branchTarget = fallThrough + (imm << 2);
	assign jumpTarget   = {fallThrough[`ID_DATA_WIDTH-1:`ID_DATA_WIDTH-4],
		instr[`ID_JIDX_HI:`ID_JIDX_LO], 2'b00};

	assign negA  = fwdA[`ID_DATA_WIDTH-1];
	assign zeroA = (fwdA == '0);

	always_comb begin
		case (branchCond)
			idPkg::BR_EQ:  taken = (fwdA == fwdB);
			idPkg::BR_NE:  taken = (fwdA != fwdB);
			idPkg::BR_LEZ: taken = negA || zeroA;
			idPkg::BR_GTZ: taken = !negA && !zeroA;
			idPkg::BR_LTZ: taken = negA;
			idPkg::BR_GEZ: taken = !negA;
			default:       taken = 1'b0;
		endcase
	end

	assign nextAddr = jumpReg ? fwdA : (jump ? jumpTarget : (taken ? branchTarget : fallThrough));
	assign redirect = jump || taken; // Flush the fetch slot

endmodule

/* verilog/idPipeReg.sv */
/* ID/EX register. Freeze holds every output, reset clears them all.
   Link instructions hand EX the fall-through address and the step to add */
`timescale 1ns/1ps
`include "id_config.svh"

module idPipeReg (
	input  logic                          CLK,
	input  logic                          RESET,
	input  logic                          freeze,
	input  logic [`ID_REG_ADDR_WIDTH-1:0] rs,
	input  logic [`ID_REG_ADDR_WIDTH-1:0] rt,
	input  logic [`ID_REG_ADDR_WIDTH-1:0] destSel,
	input  idPkg::aluOpT                  decAluOp,
	input  logic                          link,
	input  logic                          decAluSrcImm,
	input  logic                          decMemRead,
	input  logic                          decMemWrite,
	input  logic                          decMemToReg,
	input  logic                          regWrite,
	input  logic [`ID_DATA_WIDTH-1:0]     readA,
	input  logic [`ID_DATA_WIDTH-1:0]     readB,
	input  logic [`ID_DATA_WIDTH-1:0]     imm,
	input  logic [`ID_DATA_WIDTH-1:0]     instr,
	input  logic [`ID_DATA_WIDTH-1:0]     instrAddr,
	input  logic                          taken,
	input  logic [`ID_DATA_WIDTH-1:0]     nextAddr,
	output logic [`ID_DATA_WIDTH-1:0]     opA,
	output logic [`ID_DATA_WIDTH-1:0]     opB,
	output logic [`ID_DATA_WIDTH-1:0]     storeData,
	output logic [`ID_REG_ADDR_WIDTH-1:0] destReg,
	output logic [`ID_REG_ADDR_WIDTH-1:0] srcRegA,
	output logic [`ID_REG_ADDR_WIDTH-1:0] srcRegB,
	output logic [`ID_SHAMT_HI-`ID_SHAMT_LO:0] shamt,
	output idPkg::aluOpT                  aluOp,
	output logic                          aluSrcImm,
	output logic                          memRead,
	output logic                          memWrite,
	output logic                          memToReg,
	output logic                          writeBack,
	output logic                          branchTaken,
	output logic [`ID_DATA_WIDTH-1:0]     pcNext
);

	localparam logic [`ID_DATA_WIDTH-1:0] STEP = `ID_INSTR_STEP;

	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET) begin
			opA         <= '0;
			opB         <= '0;
			storeData   <= '0;
			destReg     <= '0;
			srcRegA     <= '0;
			srcRegB     <= '0;
			shamt       <= '0;
			aluOp       <= idPkg::ALU_ADD; // Zero encoding
			aluSrcImm   <= 1'b0;
			memRead     <= 1'b0;
			memWrite    <= 1'b0;
			memToReg    <= 1'b0;
			writeBack   <= 1'b0;
			branchTaken <= 1'b0;
			pcNext      <= '0;
		end else if (!freeze) begin
			opA         <= link ? instrAddr + STEP : readA;
			opB         <= link ? STEP : (decAluSrcImm ? imm : readB);
			storeData   <= readB;
			destReg     <= destSel;
			srcRegA     <= link ? '0 : rs; // EX must not forward into link operands
			srcRegB     <= (link || decAluSrcImm) ? '0 : rt;
			shamt       <= instr[`ID_SHAMT_HI:`ID_SHAMT_LO];
			aluOp       <= decAluOp;
			aluSrcImm   <= decAluSrcImm;
			memRead     <= decMemRead;
			memWrite    <= decMemWrite;
			memToReg    <= decMemToReg;
			writeBack   <= regWrite && (destSel != '0);
			branchTaken <= taken;
			pcNext      <= nextAddr;
		end
	end

endmodule

/* verilog/idStage.sv */
/* Decode stage of the five-stage pipeline, top level.
   exResult must belong to the instruction held on the registered outputs */
`timescale 1ns/1ps
`include "id_config.svh"

module idStage (
	input  logic                          CLK,
	input  logic                          RESET,
	input  logic                          freeze,
	input  logic [`ID_DATA_WIDTH-1:0]     instr,
	input  logic [`ID_DATA_WIDTH-1:0]     instrAddr,
	input  logic                          wbEnable,
	input  logic [`ID_REG_ADDR_WIDTH-1:0] wbReg,
	input  logic [`ID_DATA_WIDTH-1:0]     wbData,
	input  logic                          memWbEnable,
	input  logic [`ID_REG_ADDR_WIDTH-1:0] memWbReg,
	input  logic [`ID_DATA_WIDTH-1:0]     memData,
	input  logic [`ID_DATA_WIDTH-1:0]     exResult,
	output logic [`ID_DATA_WIDTH-1:0]     opA,
	output logic [`ID_DATA_WIDTH-1:0]     opB,
	output logic [`ID_DATA_WIDTH-1:0]     storeData,
	output logic [`ID_REG_ADDR_WIDTH-1:0] destReg,
	output logic [`ID_REG_ADDR_WIDTH-1:0] srcRegA,
	output logic [`ID_REG_ADDR_WIDTH-1:0] srcRegB,
	output logic [`ID_SHAMT_HI-`ID_SHAMT_LO:0] shamt,
	output idPkg::aluOpT                  aluOp,
	output logic                          aluSrcImm,
	output logic                          memRead,
	output logic                          memWrite,
	output logic                          memToReg,
	output logic                          writeBack,
	output logic                          branchTaken,
	output logic [`ID_DATA_WIDTH-1:0]     pcNext,
	output logic                          fetchFlush
);

	logic [`ID_REG_ADDR_WIDTH-1:0] rs, rt, destSel;
	logic [`ID_DATA_WIDTH-1:0]     imm, readA, readB, fwdA, fwdB, nextAddr;
	idPkg::aluOpT                  decAluOp;
	idPkg::branchCondT             branchCond;
	logic jump, jumpReg, link, decAluSrcImm, decMemRead, decMemWrite, decMemToReg;
	logic regWrite, taken;

	////////////////////
	// Decode and operands
	instrDecoder u_instrDecoder (
		.instr(instr), .rs(rs), .rt(rt), .destSel(destSel), .imm(imm),
		.aluOp(decAluOp), .branchCond(branchCond), .jump(jump), .jumpReg(jumpReg),
		.link(link), .aluSrcImm(decAluSrcImm), .memRead(decMemRead),
		.memWrite(decMemWrite), .memToReg(decMemToReg), .regWrite(regWrite)
	);

	regFile u_regFile (
		.CLK(CLK), .RESET(RESET), .wbEnable(wbEnable), .wbReg(wbReg),
		.wbData(wbData), .rs(rs), .rt(rt), .readA(readA), .readB(readB)
	);

	// EX producer is whatever sits in the pipe register now
	operandForward u_operandForward (
		.rs(rs), .rt(rt), .readA(readA), .readB(readB),
		.exWriteBack(writeBack), .exReg(destReg), .exResult(exResult),
		.memWbEnable(memWbEnable), .memWbReg(memWbReg), .memData(memData),
		.wbEnable(wbEnable), .wbReg(wbReg), .wbData(wbData),
		.fwdA(fwdA), .fwdB(fwdB)
	);

	////////////////////
	// Redirect and ID/EX
	branchUnit u_branchUnit (
		.instrAddr(instrAddr), .instr(instr), .imm(imm), .fwdA(fwdA), .fwdB(fwdB),
		.branchCond(branchCond), .jump(jump), .jumpReg(jumpReg),
		.taken(taken), .nextAddr(nextAddr), .redirect(fetchFlush)
	);

	idPipeReg u_idPipeReg (
		.CLK(CLK), .RESET(RESET), .freeze(freeze), .rs(rs), .rt(rt),
		.destSel(destSel), .decAluOp(decAluOp), .link(link),
		.decAluSrcImm(decAluSrcImm), .decMemRead(decMemRead),
		.decMemWrite(decMemWrite), .decMemToReg(decMemToReg), .regWrite(regWrite),
		.readA(readA), .readB(readB), .imm(imm), .instr(instr),
		.instrAddr(instrAddr), .taken(taken), .nextAddr(nextAddr),
		.opA(opA), .opB(opB), .storeData(storeData), .destReg(destReg),
		.srcRegA(srcRegA), .srcRegB(srcRegB), .shamt(shamt), .aluOp(aluOp),
		.aluSrcImm(aluSrcImm), .memRead(memRead), .memWrite(memWrite),
		.memToReg(memToReg), .writeBack(writeBack), .branchTaken(branchTaken),
		.pcNext(pcNext)
	);

endmodule

/* tests/idStageTb.sv */
/* Table-driven testbench for the decode stage top level.
   Registers 1..31 are preloaded through the write-back port and mirrored in a shadow copy */
`timescale 1ns/1ps
`include "id_config.svh"

module idStageTb;

	localparam int MAX_TESTS = 32;
	localparam int PRELOAD   = 31;
	localparam int TIMEOUT   = 3 + PRELOAD + 1 + MAX_TESTS + 1 + 20; // Cycles

	logic CLK, RESET, freeze, wbEnable, memWbEnable;
	logic [31:0] instr, instrAddr, wbData, memData, exResult;
	logic [4:0]  wbReg, memWbReg;
	logic [31:0] opA, opB, storeData, pcNext;
	logic [4:0]  destReg, srcRegA, srcRegB, shamt;
	idPkg::aluOpT aluOp;
	logic aluSrcImm, memRead, memWrite, memToReg, writeBack, branchTaken, fetchFlush;

	idStage u_dut (
		.CLK(CLK), .RESET(RESET), .freeze(freeze), .instr(instr), .instrAddr(instrAddr),
		.wbEnable(wbEnable), .wbReg(wbReg), .wbData(wbData), .memWbEnable(memWbEnable),
		.memWbReg(memWbReg), .memData(memData), .exResult(exResult), .opA(opA), .opB(opB),
		.storeData(storeData), .destReg(destReg), .srcRegA(srcRegA), .srcRegB(srcRegB),
		.shamt(shamt), .aluOp(aluOp), .aluSrcImm(aluSrcImm), .memRead(memRead),
		.memWrite(memWrite), .memToReg(memToReg), .writeBack(writeBack),
		.branchTaken(branchTaken), .pcNext(pcNext), .fetchFlush(fetchFlush)
	);

	////////////////////
	// Stimulus and expected table
	string       tName [MAX_TESTS+1]; // Last slot is the reset check
	logic [31:0] tInstr [MAX_TESTS], tAddr [MAX_TESTS], tExRes [MAX_TESTS];
	logic [31:0] tMemData [MAX_TESTS], tWbData [MAX_TESTS];
	logic [4:0]  tMemReg [MAX_TESTS], tWbReg [MAX_TESTS];
	logic        tMemEn [MAX_TESTS], tWbEn [MAX_TESTS], tFreeze [MAX_TESTS];
	logic [31:0] eOpA [MAX_TESTS], eOpB [MAX_TESTS], ePc [MAX_TESTS], eStore [MAX_TESTS];
	logic [4:0]  eDest [MAX_TESTS], eSrcB [MAX_TESTS], eAluOp [MAX_TESTS], eCtrl [MAX_TESTS];
	logic [4:0]  eSrcA [MAX_TESTS], eShamt [MAX_TESTS];
	logic        eTaken [MAX_TESTS], eFlush [MAX_TESTS];
	int          tFail [MAX_TESTS+1]; // Last slot is the reset check

	logic [31:0] sh [32]; // Shadow register file
	int nT, curIdx, errCount, failedTests, cycles, seed;

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT) begin
			$display("Timeout after %0d cycles, the table did not finish", cycles);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	function automatic logic [31:0] rType(input int rs, rt, rd, fn);
		rType = {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'd0, 6'(fn)};
	endfunction

	function automatic logic [31:0] iType(input int op, rs, rt, input logic [15:0] im);
		iType = {6'(op), 5'(rs), 5'(rt), im};
	endfunction

	function automatic logic [31:0] jType(input int op, input logic [25:0] idx);
		jType = {6'(op), idx};
	endfunction

	task automatic addTest(input string name, input logic [31:0] ins, adr, input logic frz);
		tName[nT] = name;
		tInstr[nT] = ins;
		tAddr[nT] = adr;
		tFreeze[nT] = frz;
		tExRes[nT] = '0;
		tMemEn[nT] = 1'b0;
		tMemReg[nT] = '0;
		tMemData[nT] = '0;
		tWbEn[nT] = 1'b0;
		tWbReg[nT] = '0;
		tWbData[nT] = '0;
	endtask

	// ctrl is {aluSrcImm, memRead, memWrite, memToReg, writeBack}
	task automatic expectOut(input logic [31:0] a, b, input logic [4:0] dest, op, ctrl,
		input logic tk, input logic [31:0] pc, input logic fl, input logic [31:0] st,
		input logic [4:0] srcB, srcA, sa);
		eOpA[nT] = a;
		eOpB[nT] = b;
		eDest[nT] = dest;
		eAluOp[nT] = op;
		eCtrl[nT] = ctrl;
		eTaken[nT] = tk;
		ePc[nT] = pc;
		eFlush[nT] = fl;
		eStore[nT] = st;
		eSrcB[nT] = srcB;
		eSrcA[nT] = srcA;
		eShamt[nT] = sa;
		nT++;
	endtask

	task automatic checkField(input string field, input logic [31:0] exp, act);
		assert (act === exp) else begin
			$display("** Error %s %s: expected %h, actual %h", tName[curIdx], field, exp, act);
			errCount++;
			tFail[curIdx]++;
		end
	endtask

	task automatic checkRegistered(input int k);
		checkField("opA", eOpA[k], opA);
		checkField("opB", eOpB[k], opB);
		checkField("destReg", 32'(eDest[k]), 32'(destReg));
		checkField("aluOp", 32'(eAluOp[k]), 32'(aluOp));
		checkField("ctrl", 32'(eCtrl[k]),
			32'({aluSrcImm, memRead, memWrite, memToReg, writeBack}));
		checkField("branchTaken", 32'(eTaken[k]), 32'(branchTaken));
		checkField("pcNext", ePc[k], pcNext);
		checkField("storeData", eStore[k], storeData);
		checkField("srcRegB", 32'(eSrcB[k]), 32'(srcRegB));
		checkField("srcRegA", 32'(eSrcA[k]), 32'(srcRegA));
		checkField("shamt", 32'(eShamt[k]), 32'(shamt));
	endtask

	task automatic buildTable();
		// ALU decode
		// aluOp codes ADD 0 SUB 2 OR 5 SLT 8 NOP 17
		addTest("addR", rType(1, 2, 11, 'h20), 32'h0, 0);
		expectOut(sh[1], sh[2], 11, 0, 5'b00001, 0, 32'h4, 0, sh[2], 2, 1, 0);
		addTest("subR", rType(3, 4, 12, 'h22), 32'h8, 0);
		expectOut(sh[3], sh[4], 12, 2, 5'b00001, 0, 32'hc, 0, sh[4], 4, 3, 0);
		addTest("sltR", rType(5, 6, 13, 'h2a), 32'h10, 0);
		expectOut(sh[5], sh[6], 13, 8, 5'b00001, 0, 32'h14, 0, sh[6], 6, 5, 0);
		addTest("addiNeg", iType('h08, 1, 14, 16'hfff8), 32'h18, 0);
		expectOut(sh[1], 32'hfffffff8, 14, 0, 5'b10001, 0, 32'h1c, 0, sh[14], 0, 1, 31);
		addTest("oriZext", iType('h0d, 2, 15, 16'h8001), 32'h20, 0);
		expectOut(sh[2], 32'h00008001, 15, 5, 5'b10001, 0, 32'h24, 0, sh[15], 0, 2, 0);
		// Memory
		addTest("lw", iType('h23, 3, 5, 16'h0010), 32'h24, 0);
		expectOut(sh[3], 32'h10, 5, 0, 5'b11011, 0, 32'h28, 0, sh[5], 0, 3, 0);
		addTest("sw", iType('h2b, 7, 6, 16'h0004), 32'h28, 0);
		expectOut(sh[7], 32'h4, 6, 0, 5'b10100, 0, 32'h2c, 0, sh[6], 0, 7, 0);
		// Register zero
		addTest("reg0Dest", rType(1, 2, 0, 'h20), 32'h2c, 0);
		expectOut(sh[1], sh[2], 0, 0, 5'b00000, 0, 32'h30, 0, sh[2], 2, 1, 0);
		addTest("reg0Read", rType(0, 0, 11, 'h20), 32'h30, 0);
		tWbEn[nT] = 1'b1;
		tWbReg[nT] = 5'd0;
		tWbData[nT] = 32'hdeadbeef;
		expectOut(0, 0, 11, 0, 5'b00001, 0, 32'h34, 0, 0, 0, 0, 0);
		// Branches
		// Targets are fall-through plus imm times four
		addTest("beqTaken", iType('h04, 3, 3, 16'h0004), 32'h100, 0);
		expectOut(sh[3], sh[3], 3, 17, 5'b00000, 1, 32'h114, 1, sh[3], 3, 3, 0);
		addTest("beqNotTaken", iType('h04, 3, 4, 16'hfffe), 32'h200, 0);
		expectOut(sh[3], sh[4], 4, 17, 5'b00000, 0, 32'h204, 0, sh[4], 4, 3, 31);
		addTest("bneTaken", iType('h05, 3, 4, 16'h0008), 32'h300, 0);
		expectOut(sh[3], sh[4], 4, 17, 5'b00000, 1, 32'h324, 1, sh[4], 4, 3, 0);
		addTest("bneNotTaken", iType('h05, 5, 5, 16'h0008), 32'h400, 0);
		expectOut(sh[5], sh[5], 5, 17, 5'b00000, 0, 32'h404, 0, sh[5], 5, 5, 0);
		addTest("memFwd", iType('h04, 6, 7, 16'h0003), 32'h500, 0);
		tMemEn[nT] = 1'b1;
		tMemReg[nT] = 5'd6;
		tMemData[nT] = sh[7];
		expectOut(sh[6], sh[7], 7, 17, 5'b00000, 1, 32'h510, 1, sh[7], 7, 6, 0);
		addTest("wbFwd", iType('h04, 8, 9, 16'h0005), 32'h600, 0);
		tWbEn[nT] = 1'b1;
		tWbReg[nT] = 5'd8;
		tWbData[nT] = sh[9];
		expectOut(sh[8], sh[9], 9, 17, 5'b00000, 1, 32'h618, 1, sh[9], 9, 8, 0);
		sh[8] = sh[9]; // Written at that edge
		addTest("exProducer", rType(1, 2, 9, 'h20), 32'h680, 0);
		expectOut(sh[1], sh[2], 9, 0, 5'b00001, 0, 32'h684, 0, sh[2], 2, 1, 0);
		addTest("exWins", iType('h04, 9, 10, 16'h0002), 32'h700, 0);
		tExRes[nT] = sh[10];
		tMemEn[nT] = 1'b1;
		tMemReg[nT] = 5'd9;
		tMemData[nT] = sh[10] + 32'd5;
		expectOut(sh[9], sh[10], 10, 17, 5'b00000, 1, 32'h70c, 1, sh[10], 10, 9, 0);
		// Jumps
		// j index 0x0123456 overlaps rs 0, rt 18 and shamt 17
		addTest("jump", jType('h02, 26'h0123456), 32'h10000100, 0);
		expectOut(0, sh[18], 18, 17, 5'b00000, 0, 32'h1048d158, 1, sh[18], 18, 0, 17);
		// jal index 0x0430040 overlaps rs 2 and rt 3, both zeroed for the link
		addTest("jal", jType('h03, 26'h0430040), 32'h2000, 0);
		expectOut(32'h2004, 32'h4, 31, 0, 5'b00001, 0, 32'h010c0100, 1, sh[3], 0, 0, 1);
		addTest("jrFwd", rType(12, 0, 0, 'h08), 32'h3000, 0);
		tMemEn[nT] = 1'b1;
		tMemReg[nT] = 5'd12;
		tMemData[nT] = 32'h00abc000;
		expectOut(sh[12], 0, 0, 17, 5'b00000, 0, 32'h00abc000, 1, 0, 0, 12, 0);
		// Freeze keeps the jr outputs
		addTest("freezeHold", rType(1, 2, 11, 'h20), 32'h4000, 1);
		expectOut(eOpA[nT-1], eOpB[nT-1], eDest[nT-1], eAluOp[nT-1], eCtrl[nT-1],
			eTaken[nT-1], ePc[nT-1], 0, eStore[nT-1], eSrcB[nT-1], eSrcA[nT-1],
			eShamt[nT-1]);
	endtask

	initial begin
		RESET = 1'b0;
		freeze = 1'b0;
		instr = '0;
		instrAddr = '0;
		wbEnable = 1'b0;
		wbReg = '0;
		wbData = '0;
		memWbEnable = 1'b0;
		memWbReg = '0;
		memData = '0;
		exResult = '0;
		cycles = 0;
		errCount = 0;
		failedTests = 0;
		nT = 0;
		seed = 32'h27d53ac9;
		for (int r = 0; r <= MAX_TESTS; r++) tFail[r] = 0;
		sh[0] = '0;

		repeat (3) @(posedge CLK);
		RESET <= 1'b1;
		@(negedge CLK);
		curIdx = MAX_TESTS;
		tName[MAX_TESTS] = "reset";
		checkField("opA", 0, opA);
		checkField("opB", 0, opB);
		checkField("storeData", 0, storeData);
		checkField("pcNext", 0, pcNext);
		checkField("destReg", 0, 32'(destReg));
		checkField("srcRegA", 0, 32'(srcRegA));
		checkField("srcRegB", 0, 32'(srcRegB));
		checkField("shamt", 0, 32'(shamt));
		checkField("aluOp", 0, 32'(aluOp));
		checkField("ctrl", 0, 32'({aluSrcImm, memRead, memWrite, memToReg, writeBack}));
		checkField("branchTaken", 0, 32'(branchTaken));
		$display("test reset: %s", (tFail[MAX_TESTS] == 0) ? "ok" : "failed");
		if (tFail[MAX_TESTS] != 0) failedTests++;

		// Preload through the write-back port
		for (int r = 1; r <= PRELOAD; r++) begin
			@(posedge CLK);
			sh[r] = $random(seed);
			wbEnable <= 1'b1;
			wbReg <= 5'(r);
			wbData <= sh[r];
		end
		@(posedge CLK);
		wbEnable <= 1'b0;

		buildTable();
		for (int i = 0; i <= nT; i++) begin
			@(posedge CLK);
			if (i < nT) begin
				instr <= tInstr[i];
				instrAddr <= tAddr[i];
				freeze <= tFreeze[i];
				exResult <= tExRes[i];
				memWbEnable <= tMemEn[i];
				memWbReg <= tMemReg[i];
				memData <= tMemData[i];
				wbEnable <= tWbEn[i];
				wbReg <= tWbReg[i];
				wbData <= tWbData[i];
			end else begin
				freeze <= 1'b1;
				wbEnable <= 1'b0;
				memWbEnable <= 1'b0;
			end
			@(negedge CLK);
			if (i > 0) begin
				curIdx = i - 1;
				checkRegistered(i - 1);
				$display("test %s: %s", tName[i-1], (tFail[i-1] == 0) ? "ok" : "failed");
				if (tFail[i-1] != 0) failedTests++;
			end
			if (i < nT) begin
				curIdx = i;
				checkField("fetchFlush", 32'(eFlush[i]), 32'(fetchFlush));
			end
		end

		$display("tests %0d, failed %0d, errors %0d", nT + 1, failedTests, errCount);
		if (errCount == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

/* sources.f */
+incdir+verilog
verilog/idPkg.sv
verilog/instrDecoder.sv
verilog/regFile.sv
verilog/operandForward.sv
verilog/branchUnit.sv
verilog/idPipeReg.sv
verilog/idStage.sv
tests/idStageTb.sv

/* run.sh */
#!/bin/sh
# Build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -f sources.f --top-module idStageTb -o simIdStage

output=$(./obj_dir/simIdStage)
echo "$output"

if echo "$output" | grep -qx "STATUS: PASS"; then
	exit 0
else
	exit 1
fi
